// ==== logic/cmp_rx_pkg.sv ====
package cmp_rx_pkg;

	// --------------------
	// Word and frame sizes
	localparam int word_w      = 16;  // One decoded transceiver word
	localparam int flag_w      = 2;   // Per-byte flag pairs from the decoder
	localparam int frame_words = 4;   // K word plus three data words
	localparam int payload_w   = 48;  // Three data words side by side

	// --------------------
	// Code values
	localparam logic [flag_w-1:0] isk_kword = 2'b01;  // Comma in the low byte only
	localparam logic [flag_w-1:0] isk_data  = 2'b00;  // Plain data word

	localparam logic [7:0] k_comma_lt = 8'hFC;  // K28.7 marks the latency trigger

	// Bits 4 to 1 of the K byte
	// 1C,3C,5C,7C,9C,BC,DC,FC all carry this, so the K byte can code 3 extra bits
	localparam logic [3:0] eof_code = 4'hE;

	// --------------------
	// Link monitor
	localparam int good_frames_needed = 16;  // Clean frames in a row before link good
	localparam int good_count_w       = $clog2(good_frames_needed);

	localparam int               err_count_w    = 8;
	localparam logic [7:0]       err_count_stop = 8'hE0;  // Loss counter parks here

	localparam int               code_count_w    = 16;
	localparam logic [15:0]      code_count_stop = 16'hFFFE;  // Code-error counters park here

	// Two readings of one transceiver word
	typedef struct packed {
		logic [7:0] payload;  // Spare data byte of the K word
		logic [7:0] kbyte;    // Comma or EOF code
	} k_view_t;

	typedef union packed {
		logic [word_w-1:0] raw;  // Data words
		k_view_t           k;    // First word of a frame
	} frame_word_u;

endpackage

// ==== logic/cmp_rx_phase.sv ====
`timescale 1ns/1ns

module cmp_rx_phase import cmp_rx_pkg::*; (
	input  logic                   CMP_RX_CLK160,
	input  logic                   cmp_rx_resetdone,
	input  logic                   rx_sync_done,     // Phase alignment finished
	input  logic                   ttc_resync,       // Clears the link status
	input  logic [flag_w-1:0]      rx_isk,
	output logic                   rx_rst_done,
	output logic                   frame_clr,
	output logic [frame_words-1:0] frame_phase       // Bit n high while word n is on rx_data
);

	logic rst_done_r;   // First retiming stage
	logic rst_done_r2;  // Synchronised reset-done
	logic k_seen;

	// --------------------
	// Reset-done retiming
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			rst_done_r  <= 1'b0;
			rst_done_r2 <= 1'b0;
		end else begin
			rst_done_r  <= 1'b1;
			rst_done_r2 <= rst_done_r;
		end
	end

	assign rx_rst_done = rst_done_r;

	// One clear for every downstream block
	assign frame_clr = !rst_done_r2 || !rx_sync_done || ttc_resync;

	// --------------------
	// Frame phase
	assign k_seen = (rx_isk == isk_kword);  // Comma in the low byte opens a frame

	// K word at t gives bit 1 at t+1, then 2, 3 and 0
	// A second K word while one frame runs puts a second bit in flight
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			frame_phase <= '0;
		end else if (frame_clr) begin
			frame_phase <= '0;
		end else begin
			frame_phase <= {frame_phase[frame_words-2:1], k_seen,
			                frame_phase[frame_words-1]};
		end
	end

endmodule

// ==== logic/cmp_rx_frame.sv ====
`timescale 1ns/1ns

module cmp_rx_frame import cmp_rx_pkg::*; (
	input  logic                   CMP_RX_CLK160,
	input  logic                   cmp_rx_resetdone,
	input  logic                   frame_clr,
	input  logic [frame_words-1:0] frame_phase,
	input  frame_word_u            rx_data,
	input  logic [flag_w-1:0]      rx_isk,
	input  logic [flag_w-1:0]      rx_notintable,
	input  logic                   rx_lossofsync,
	output logic [payload_w-1:0]   rcv_data,      // {word 3, word 2, word 1}
	output logic [word_w-1:0]      rcv_kchar,     // K word that opened the frame
	output logic [3:1]             nonzero_word,  // Index is the data word number
	output logic                   ltncy_trig,
	output logic                   frame_done,    // One cycle per finished frame
	output logic                   frame_ok
);

	logic              k_arrive;
	logic              word_clean;    // Decoder in sync and symbol in table
	logic              k_word_ok;
	logic              data_word_ok;
	logic              last_word;

	logic [word_w-1:0] k_hold;        // K word of the youngest frame
	logic [word_w-1:0] w1_hold;
	logic [word_w-1:0] w2_hold;

	logic              k_ok;
	logic              lt_hold;
	logic              w1_ok;
	logic              w2_ok;

	// --------------------
	// Per-word checks
	assign k_arrive   = (rx_isk == isk_kword);
	assign word_clean = !rx_lossofsync && (rx_notintable == '0);

	// K flags already match when k_arrive is set
	assign k_word_ok    = word_clean && (rx_data.k.kbyte[4:1] == eof_code);
	assign data_word_ok = word_clean && (rx_isk == isk_data);  // No K bits inside the data

	assign last_word = frame_phase[frame_words-1];  // Word 3 on the bus

	// --------------------
	// Word capture
	always_ff @(posedge CMP_RX_CLK160) begin
		if (k_arrive) begin
			k_hold <= rx_data.raw;  // Taken on arrival, latest K word wins
		end
		if (frame_phase[1]) begin
			w1_hold <= rx_data.raw;
		end
		if (frame_phase[2]) begin
			w2_hold <= rx_data.raw;
		end
	end

	// Check results of the words held so far
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			k_ok    <= 1'b0;
			lt_hold <= 1'b0;
			w1_ok   <= 1'b0;
			w2_ok   <= 1'b0;
		end else if (frame_clr) begin
			k_ok    <= 1'b0;
			lt_hold <= 1'b0;
			w1_ok   <= 1'b0;
			w2_ok   <= 1'b0;
		end else begin
			if (k_arrive) begin
				k_ok    <= k_word_ok;
				lt_hold <= (rx_data.k.kbyte == k_comma_lt);
			end
			if (frame_phase[1]) w1_ok <= data_word_ok;
			if (frame_phase[2]) w2_ok <= data_word_ok;
		end
	end

	// --------------------
	// Frame output at t+4, zero in every other cycle
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			rcv_data     <= '0;
			rcv_kchar    <= '0;
			nonzero_word <= '0;
			ltncy_trig   <= 1'b0;
			frame_done   <= 1'b0;
			frame_ok     <= 1'b0;
		end else if (frame_clr || !last_word) begin
			rcv_data     <= '0;
			rcv_kchar    <= '0;
			nonzero_word <= '0;
			ltncy_trig   <= 1'b0;
			frame_done   <= 1'b0;
			frame_ok     <= 1'b0;
		end else begin
			rcv_data     <= {rx_data.raw, w2_hold, w1_hold};  // Third word straight from the bus
			rcv_kchar    <= k_hold;
			nonzero_word <= {|rx_data.raw, |w2_hold, |w1_hold};
			ltncy_trig   <= lt_hold;
			frame_done   <= 1'b1;
			frame_ok     <= k_ok && w1_ok && w2_ok && data_word_ok;
		end
	end

endmodule

// ==== logic/cmp_rx_link_mon.sv ====
`timescale 1ns/1ns

module cmp_rx_link_mon import cmp_rx_pkg::*; (
	input  logic                    CMP_RX_CLK160,
	input  logic                    cmp_rx_resetdone,
	input  logic                    frame_clr,
	input  logic [frame_words-1:0]  frame_phase,
	input  logic                    frame_done,
	input  logic                    frame_ok,
	input  logic                    force_error,       // Asynchronous error injection
	input  logic [flag_w-1:0]       rx_notintable,
	input  logic [flag_w-1:0]       rx_disperr,
	output logic                    link_good,
	output logic                    link_had_err,
	output logic                    link_bad,
	output logic [err_count_w-1:0]  err_count,         // Times the link was lost
	output logic [code_count_w-1:0] notintable_count,
	output logic [code_count_w-1:0] disperr_count
);

	logic [good_count_w-1:0] good_count;
	logic                    no_streak;      // No good frame since the last break
	logic                    went_down_seen; // Sticky
	logic                    eof_pend;       // Previous cycle was t+4 of some frame
	logic [1:0]              force_sr;

	logic                    frame_bad;
	logic                    missing_k;
	logic                    streak_break;
	logic                    link_went_down;
	logic                    err_inj;
	logic                    in_frame;

	// Saturating step shared by both code-error counters
	function automatic logic [code_count_w-1:0] code_step(
		input logic [code_count_w-1:0] count,
		input logic                    hit
	);
		logic [code_count_w-1:0] next;
		next = count;
		if (hit && (count != code_count_stop)) next = count + 1'b1;
		return next;
	endfunction

	// --------------------
	// Frame checks
	assign frame_bad = frame_done && !frame_ok;

	// No K word at t+4 means no bit 1 at t+5
	assign missing_k = eof_pend && !frame_phase[1];

	assign streak_break   = frame_bad || missing_k;
	assign link_went_down = link_good && streak_break;

	assign link_had_err = went_down_seen || no_streak;
	assign link_bad     = err_count[err_count_w-1];

	// Rising edge of the retimed request
	assign err_inj  = force_sr[0] && !force_sr[1];
	assign in_frame = |frame_phase;

	// --------------------
	// Good-frame streak and link status
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			eof_pend       <= 1'b0;
			good_count     <= '0;
			no_streak      <= 1'b1;  // Never alive yet
			link_good      <= 1'b0;
			went_down_seen <= 1'b0;
		end else if (frame_clr) begin
			eof_pend       <= 1'b0;
			good_count     <= '0;
			no_streak      <= 1'b1;
			link_good      <= 1'b0;
			went_down_seen <= 1'b0;
		end else begin
			eof_pend <= frame_phase[0];
			if (streak_break) begin
				good_count <= '0;
				no_streak  <= 1'b1;
				link_good  <= 1'b0;
			end else if (frame_done) begin  // Good frame here
				no_streak <= 1'b0;
				if (!link_good) begin
					if (good_count == good_count_w'(good_frames_needed - 1)) begin
						link_good <= 1'b1;  // 16th clean frame
					end else begin
						good_count <= good_count + 1'b1;
					end
				end
			end
			if (link_went_down) went_down_seen <= 1'b1;
		end
	end

	// --------------------
	// Loss counter with injection
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			force_sr  <= '0;
			err_count <= '0;
		end else begin
			force_sr <= {force_sr[0], force_error};  // Keeps running through a clear
			if (frame_clr) begin
				err_count <= '0;
			end else if ((link_went_down || err_inj) && (err_count != err_count_stop)) begin
				err_count <= err_count + 1'b1;  // Both in one cycle count once
			end
		end
	end

	// Code errors, one count per flagged word
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			notintable_count <= '0;
			disperr_count    <= '0;
		end else if (frame_clr) begin
			notintable_count <= '0;
			disperr_count    <= '0;
		end else if (in_frame) begin
			notintable_count <= code_step(notintable_count, |rx_notintable);
			disperr_count    <= code_step(disperr_count, |rx_disperr);
		end
	end

endmodule

// ==== logic/cmp_fiber_rx.sv ====
`timescale 1ns/1ns

module cmp_fiber_rx import cmp_rx_pkg::*; (
	input  logic                    CMP_RX_CLK160,
	input  logic                    cmp_rx_resetdone,
	input  logic                    rx_sync_done,
	input  logic                    ttc_resync,
	input  logic                    force_error,
	input  frame_word_u             rx_data,
	input  logic [flag_w-1:0]       rx_isk,
	input  logic [flag_w-1:0]       rx_notintable,
	input  logic [flag_w-1:0]       rx_disperr,
	input  logic                    rx_lossofsync,
	output logic                    rx_rst_done,
	output logic                    frame_clr,
	output logic [frame_words-1:0]  frame_phase,
	output logic [payload_w-1:0]    rcv_data,
	output logic [word_w-1:0]       rcv_kchar,
	output logic [3:1]              nonzero_word,
	output logic                    ltncy_trig,
	output logic                    frame_done,
	output logic                    frame_ok,
	output logic                    link_good,
	output logic                    link_had_err,
	output logic                    link_bad,
	output logic [err_count_w-1:0]  err_count,
	output logic [code_count_w-1:0] notintable_count,
	output logic [code_count_w-1:0] disperr_count
);

	// --------------------
	// Reset-done, clear and frame phase
	cmp_rx_phase u_phase (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_sync_done     (rx_sync_done),
		.ttc_resync       (ttc_resync),
		.rx_isk           (rx_isk),
		.rx_rst_done      (rx_rst_done),
		.frame_clr        (frame_clr),
		.frame_phase      (frame_phase)
	);

	// Payload assembly
	cmp_rx_frame u_frame (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.frame_clr        (frame_clr),
		.frame_phase      (frame_phase),
		.rx_data          (rx_data),
		.rx_isk           (rx_isk),
		.rx_notintable    (rx_notintable),
		.rx_lossofsync    (rx_lossofsync),
		.rcv_data         (rcv_data),
		.rcv_kchar        (rcv_kchar),
		.nonzero_word     (nonzero_word),
		.ltncy_trig       (ltncy_trig),
		.frame_done       (frame_done),
		.frame_ok         (frame_ok)
	);

	// Link health and code-error counts
	cmp_rx_link_mon u_link_mon (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.frame_clr        (frame_clr),
		.frame_phase      (frame_phase),
		.frame_done       (frame_done),
		.frame_ok         (frame_ok),
		.force_error      (force_error),
		.rx_notintable    (rx_notintable),
		.rx_disperr       (rx_disperr),
		.link_good        (link_good),
		.link_had_err     (link_had_err),
		.link_bad         (link_bad),
		.err_count        (err_count),
		.notintable_count (notintable_count),
		.disperr_count    (disperr_count)
	);

endmodule

// ==== bench/cmp_fiber_rx_chk.sv ====
`timescale 1ns/1ns

module cmp_fiber_rx_chk import cmp_rx_pkg::*; (
	input logic                    CMP_RX_CLK160,
	input logic                    cmp_rx_resetdone,
	input logic                    frame_clr,
	input logic [frame_words-1:0]  frame_phase,
	input logic [payload_w-1:0]    rcv_data,
	input logic [word_w-1:0]       rcv_kchar,
	input logic [3:1]              nonzero_word,
	input logic                    ltncy_trig,
	input logic                    frame_done,
	input logic                    link_good,
	input logic                    link_bad,
	input logic [err_count_w-1:0]  err_count,
	input logic [code_count_w-1:0] notintable_count,
	input logic [code_count_w-1:0] disperr_count
);

	// --------------------
	// Phase walk 1, 2, 3, 0
	a_ph12: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone || frame_clr)
		frame_phase[1] |=> frame_phase[2]) else $error("frame_phase bit 2 did not follow bit 1");
	a_ph23: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone || frame_clr)
		frame_phase[2] |=> frame_phase[3]) else $error("frame_phase bit 3 did not follow bit 2");
	a_ph30: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone || frame_clr)
		frame_phase[3] |=> frame_phase[0]) else $error("frame_phase bit 0 did not follow bit 3");

	// Trigger only with a K word
	a_trig: assert property (@(posedge CMP_RX_CLK160) ltncy_trig |-> (rcv_kchar != '0))
		else $error("ltncy_trig with zero rcv_kchar");

	// Loss counter parks at E0
	a_sat: assert property (@(posedge CMP_RX_CLK160) err_count <= err_count_stop)
		else $error("err_count above its saturation value");

	// Everything zero one cycle into a clear
	a_clr: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		frame_clr |=> (rcv_data == '0 && rcv_kchar == '0 && nonzero_word == '0 && !ltncy_trig
		&& !frame_done && !link_good && !link_bad && err_count == '0 && notintable_count == '0
		&& disperr_count == '0 && frame_phase == '0)) else $error("Outputs not cleared");

endmodule

// ==== bench/tb_cmp_fiber_rx.sv ====
`timescale 1ns/1ns

module tb_cmp_fiber_rx import cmp_rx_pkg::*; ();

	logic CMP_RX_CLK160, cmp_rx_resetdone, rx_sync_done, ttc_resync, force_error, rx_lossofsync;
	logic [15:0] rx_data;
	logic [1:0]  rx_isk, rx_notintable, rx_disperr;
	logic rx_rst_done, frame_clr, ltncy_trig, frame_done, frame_ok;
	logic link_good, link_had_err, link_bad;
	logic [3:0]  frame_phase;
	logic [47:0] rcv_data;
	logic [15:0] rcv_kchar, notintable_count, disperr_count;
	logic [3:1]  nonzero_word;
	logic [7:0]  err_count;

	logic [31:0] lfsr = 32'h3aa7;
	logic [68:0] exp_q[$];  // {ok, trig, nonzero, kchar, payload}
	int errors = 0, tests_failed = 0, test_base = 0, timeout_cycles;
	// Expected link state
	bit m_good, m_down, m_no_streak = 1;
	int m_streak = 0;
	logic [7:0] m_err = '0;
	logic [15:0] m_nit = '0, m_dis = '0;

	cmp_fiber_rx u_cmp_fiber_rx (.*);

	bind cmp_fiber_rx cmp_fiber_rx_chk u_chk (.CMP_RX_CLK160(CMP_RX_CLK160),
		.cmp_rx_resetdone(cmp_rx_resetdone), .frame_clr(frame_clr), .frame_phase(frame_phase),
		.rcv_data(rcv_data), .rcv_kchar(rcv_kchar), .nonzero_word(nonzero_word),
		.ltncy_trig(ltncy_trig), .frame_done(frame_done), .link_good(link_good),
		.link_bad(link_bad), .err_count(err_count), .notintable_count(notintable_count),
		.disperr_count(disperr_count));

	initial begin
		CMP_RX_CLK160 = 1'b0;
		forever #2 CMP_RX_CLK160 = !CMP_RX_CLK160;  // 4 ns period
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Expected frame result from the four words sent
	function automatic logic [68:0] ref_frame(input logic [63:0] w, input logic [7:0] isk,
	                                           input logic [7:0] nit, input logic [3:0] los);
		logic       ok;
		logic [2:0] nz;
		ok = (isk[1:0] == 2'b01) && (w[4:1] == 4'hE);  // K word with EOF code
		for (int i = 0; i < 4; i++) begin
			ok = ok && !los[i] && (nit[2*i +: 2] == 2'b00);
			if (i > 0) begin
				ok = ok && (isk[2*i +: 2] == 2'b00);  // Data words carry no K
				nz[i-1] = |w[16*i +: 16];
			end
		end
		return {ok, w[7:0] == 8'hFC, nz, w[15:0], w[63:16]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// Link model
	task automatic link_break();
		if (m_good && m_err != err_count_stop) m_err++;
		if (m_good) m_down = 1'b1;
		m_good = 1'b0;
		m_streak = 0;
		m_no_streak = 1'b1;
	endtask

	task automatic model_clear();
		m_good = 0;
		m_down = 0;
		m_no_streak = 1;
		m_streak = 0;
		m_err = '0;
		m_nit = '0;
		m_dis = '0;
	endtask

	// kind 0 clean, 1 K flag in word 2, 2 random code errors
	task automatic send_frame(input int kind, input bit last);
		logic [63:0] w;
		logic [7:0]  isk, nit, dis;
		logic [3:0]  los;
		logic [31:0] r;
		logic [68:0] e;
		w = '0;
		isk = 8'h01;
		nit = '0;
		dis = '0;
		los = '0;
		r = take_bits(11);
		w[15:0] = {r[10:3], r[2:0], 4'hE, 1'b0};  // Eight EOF codes, FC among them
		for (int i = 1; i < 4; i++) begin
			r = take_bits(2);
			if (r[1:0] != 0) begin
				r = take_bits(16);
				w[16*i +: 16] = r[15:0];
			end
			if (kind == 2) begin
				r = take_bits(4);
				if (r[1:0] == 0) nit[2*i +: 2] = r[2] ? 2'b10 : 2'b01;
				if (r[3] == 0) dis[2*i +: 2] = 2'b01;
			end
		end
		if (kind == 1) isk[5:4] = 2'b10;
		if (kind == 2) begin
			r = take_bits(7);
			if (r[2:0] == 0) w[1] = ~w[1];  // EOF code broken
			if (r[4:3] == 0) los[r[6:5]] = 1'b1;  // Sync lost on one word
		end
		for (int i = 0; i < 4; i++) begin
			@(posedge CMP_RX_CLK160);
			rx_data       <= w[16*i +: 16];
			rx_isk        <= isk[2*i +: 2];
			rx_notintable <= nit[2*i +: 2];
			rx_disperr    <= dis[2*i +: 2];
			rx_lossofsync <= los[i];
		end
		e = ref_frame(w, isk, nit, los);
		exp_q.push_back(e);
		for (int i = 1; i < 4; i++) begin
			if (|nit[2*i +: 2] && m_nit != code_count_stop) m_nit++;
			if (|dis[2*i +: 2] && m_dis != code_count_stop) m_dis++;
		end
		if (!e[68]) begin
			link_break();
		end else begin
			m_no_streak = 0;
			if (!m_good && m_streak == good_frames_needed - 1) m_good = 1;
			else if (!m_good) m_streak++;
		end
		if (last) begin  // Idle word where the next K should be
			@(posedge CMP_RX_CLK160);
			{rx_data, rx_isk, rx_notintable, rx_disperr, rx_lossofsync} <= '0;
			link_break();
		end
	endtask

	task automatic check_status();
		repeat (6) @(posedge CMP_RX_CLK160);
		@(negedge CMP_RX_CLK160);
		check_value("link_good", 64'(link_good), 64'(m_good));
		check_value("link_had_err", 64'(link_had_err), 64'(m_down || m_no_streak));
		check_value("err_count", 64'(err_count), 64'(m_err));
		check_value("link_bad", 64'(link_bad), 64'(m_err[7]));
		check_value("notintable_count", 64'(notintable_count), 64'(m_nit));
		check_value("disperr_count", 64'(disperr_count), 64'(m_dis));
	endtask

	task automatic resync_link();
		@(posedge CMP_RX_CLK160) ttc_resync <= 1'b1;
		@(negedge CMP_RX_CLK160);
		check_value("frame_clr", 64'(frame_clr), 64'd1);  // Clear follows the resync request
		repeat (2) @(posedge CMP_RX_CLK160);
		ttc_resync <= 1'b0;
		model_clear();
	endtask

	task automatic end_test(input int n, input string name);
		if (errors != test_base) tests_failed++;
		$display("Test %0d %s: %s", n, name, (errors == test_base) ? "ok" : "FAILED");
		test_base = errors;
	endtask

	// --------------------
	// Compare each frame result with the queue
	initial begin : compare
		logic [68:0] e;
		forever begin
			@(negedge CMP_RX_CLK160);
			if (frame_done) begin
				if (exp_q.size() == 0) begin
					$display("Frame result at %0t ns with no frame sent", $time);
					errors++;
				end else begin
					e = exp_q.pop_front();
					check_value("rcv_data", 64'(rcv_data), 64'(e[47:0]));
					check_value("rcv_kchar", 64'(rcv_kchar), 64'(e[63:48]));
					check_value("nonzero_word", 64'(nonzero_word), 64'(e[66:64]));
					check_value("ltncy_trig", 64'(ltncy_trig), 64'(e[67]));
					check_value("frame_ok", 64'(frame_ok), 64'(e[68]));
				end
			end else if (rcv_data != '0 || rcv_kchar != '0 || nonzero_word != '0
			             || ltncy_trig || frame_ok) begin
				$display("Frame outputs not zero outside t+4 at %0t ns", $time);
				errors++;
			end
		end
	end

	initial begin : watchdog
		timeout_cycles = 130 * frame_words + 232 * 4 + 600;  // Frames, force pulses, margin
		repeat (timeout_cycles) @(posedge CMP_RX_CLK160);
		$display("Watchdog expired after %0d cycles, run did not finish", timeout_cycles);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : stimulus
		cmp_rx_resetdone <= 1'b0;
		{rx_sync_done, ttc_resync, force_error, rx_lossofsync} <= '0;
		{rx_data, rx_isk, rx_notintable, rx_disperr} <= '0;
		repeat (4) @(posedge CMP_RX_CLK160);
		@(negedge CMP_RX_CLK160);
		check_value("rx_rst_done", 64'(rx_rst_done), 64'd0);  // Still in reset
		check_value("frame_clr", 64'(frame_clr), 64'd1);
		@(posedge CMP_RX_CLK160);
		cmp_rx_resetdone <= 1'b1;
		rx_sync_done     <= 1'b1;
		repeat (4) @(posedge CMP_RX_CLK160);
		@(negedge CMP_RX_CLK160);
		check_value("rx_rst_done", 64'(rx_rst_done), 64'd1);
		check_value("frame_clr", 64'(frame_clr), 64'd0);  // Retiming done, link running

		for (int i = 0; i < 40; i++) send_frame(0, i == 39);
		check_status();
		end_test(1, "random frames");

		resync_link();
		for (int i = 0; i < 17; i++) send_frame(0, 0);
		@(negedge CMP_RX_CLK160);
		check_value("link_good", 64'(link_good), 64'd1);  // Good after 16 frames
		check_value("link_had_err", 64'(link_had_err), 64'd0);
		send_frame(0, 1);
		check_status();
		end_test(2, "link good");

		resync_link();
		for (int i = 0; i < 17; i++) send_frame(0, 0);
		send_frame(1, 0);  // K inside data
		for (int i = 0; i < 17; i++) send_frame(0, i == 16);  // Then missing K
		check_status();
		end_test(3, "link loss");

		resync_link();
		for (int i = 0; i < 12; i++) send_frame(2, i == 11);
		check_status();
		end_test(4, "code errors");

		resync_link();
		for (int i = 0; i < 232; i++) begin
			@(posedge CMP_RX_CLK160) force_error <= 1'b1;
			@(posedge CMP_RX_CLK160);
			@(posedge CMP_RX_CLK160) force_error <= 1'b0;
			@(posedge CMP_RX_CLK160);
			if (m_err != err_count_stop) m_err++;
		end
		check_status();
		end_test(5, "forced errors");

		resync_link();
		for (int i = 0; i < 20; i++) send_frame(2, i == 19);
		resync_link();
		check_status();
		for (int i = 0; i < 5; i++) send_frame(2, i == 4);
		@(posedge CMP_RX_CLK160) rx_sync_done <= 1'b0;
		model_clear();
		check_status();
		@(posedge CMP_RX_CLK160) rx_sync_done <= 1'b1;
		end_test(6, "clear");

		repeat (4) @(posedge CMP_RX_CLK160);
		if (exp_q.size() != 0) begin
			$display("%0d frames sent got no frame result", exp_q.size());
			errors++;
		end
		$display("Tests run 6, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/cmp_rx_pkg.sv
logic/cmp_rx_phase.sv
logic/cmp_rx_frame.sv
logic/cmp_rx_link_mon.sv
logic/cmp_fiber_rx.sv
bench/cmp_fiber_rx_chk.sv
bench/tb_cmp_fiber_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fiber receive testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_cmp_fiber_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cmp_fiber_rx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "No result line in sim.log"
	exit 1
fi
exit 0
